//--- logic/hm_defs.svh
`ifndef HM_DEFS_SVH
`define HM_DEFS_SVH

// address split: | tag | index | line offset |
`define HM_ADDR_W    16
`define HM_OFFSET_W  4
`define HM_INDEX_W   4
`define HM_TAG_W     8

// bit positions of the fields inside an address
`define HM_INDEX_LSB (`HM_OFFSET_W)
`define HM_TAG_LSB   (`HM_OFFSET_W + `HM_INDEX_W)

// set and way geometry
`define HM_NUM_SETS  (1 << `HM_INDEX_W)
`define HM_NUM_WAYS  2

// descriptor ids and per-id miss counters
`define HM_ID_W      2
`define HM_NUM_IDS   (1 << `HM_ID_W)
`define HM_CNT_W     3
// counter saturates here, the unit stalls at this value
`define HM_CNT_MAX   ((1 << `HM_CNT_W) - 1)

`endif

//--- logic/hm_addr_pkg.sv
`include "hm_defs.svh"

package hm_addr_pkg;

  ////////////////////
  // address fields
  ////////////////////

  // full access address
  typedef logic [`HM_ADDR_W-1:0]  addr_t;
  // tag part, compared against the tag store
  typedef logic [`HM_TAG_W-1:0]   tag_t;
  // set index
  typedef logic [`HM_INDEX_W-1:0] index_t;

  ////////////////////
  // descriptor bookkeeping
  ////////////////////

  // descriptor id
  typedef logic [`HM_ID_W-1:0]    id_t;
  // outstanding misses of one id
  typedef logic [`HM_CNT_W-1:0]   cnt_t;

endpackage

//--- logic/hm_ctrl_pkg.sv
`include "hm_defs.svh"

package hm_ctrl_pkg;

  // one-hot way select, bit n is way n
  typedef logic [`HM_NUM_WAYS-1:0] way_ind_t;

  ////////////////////
  // state machines
  ////////////////////

  // tag store: sweep over all sets after reset, then serve lookups
  typedef enum logic {
    INIT_CLEAR,
    READY
  } store_state_e;

  // hit/miss unit: empty, or holding one descriptor
  typedef enum logic {
    IDLE,
    HOLD
  } unit_state_e;

endpackage

//--- logic/tag_store.sv
`include "hm_defs.svh"

module tag_store
  import hm_addr_pkg::*;
  import hm_ctrl_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     lookup_valid_i,
  input  addr_t    lookup_addr_i,
  input  logic     lookup_rw_i,
  output logic     store_ready_o,
  output logic     res_hit_o,
  output way_ind_t res_way_o,
  output logic     res_evict_o,
  output tag_t     res_evict_tag_o
);

  store_state_e state_q;
  store_state_e state_d;
  // set that gets cleared in this cycle during the sweep
  index_t       clear_idx_q;

  // per set and way storage
  tag_t                                      tag_q [`HM_NUM_SETS][`HM_NUM_WAYS];
  logic [`HM_NUM_SETS-1:0][`HM_NUM_WAYS-1:0] valid_q;
  logic [`HM_NUM_SETS-1:0][`HM_NUM_WAYS-1:0] dirty_q;
  // round robin victim pointer, one per set
  logic [`HM_NUM_SETS-1:0]                   victim_q;

  index_t   lu_index;
  tag_t     lu_tag;
  way_ind_t hit_vec;
  logic     lu_hit;
  logic     vic_sel;
  way_ind_t vic_ind;
  logic     vic_evict;
  logic     do_lookup;

  ////////////////////
  // lookup compare
  ////////////////////

  assign lu_index = lookup_addr_i[`HM_INDEX_LSB +: `HM_INDEX_W];
  assign lu_tag   = lookup_addr_i[`HM_TAG_LSB +: `HM_TAG_W];

  // a way hits when it is valid and its tag matches
  always_comb begin
    for (int w = 0; w < `HM_NUM_WAYS; w++) begin
      hit_vec[w] = valid_q[lu_index][w] && (tag_q[lu_index][w] == lu_tag);
    end
  end

  assign lu_hit    = |hit_vec;
  assign vic_sel   = victim_q[lu_index];
  assign vic_ind   = way_ind_t'(1) << vic_sel;
  // only a dirty line has to be written back
  assign vic_evict = valid_q[lu_index][vic_sel] & dirty_q[lu_index][vic_sel];

  ////////////////////
  // init sweep
  ////////////////////

  assign store_ready_o = (state_q == READY);
  // lookups are ignored while clearing
  assign do_lookup     = lookup_valid_i & store_ready_o;

  always_comb begin
    state_d = state_q;
    // last set cleared, open up for lookups
    if ((state_q == INIT_CLEAR) && (clear_idx_q == index_t'(`HM_NUM_SETS - 1))) begin
      state_d = READY;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= INIT_CLEAR;
      clear_idx_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == INIT_CLEAR) begin
        clear_idx_q <= clear_idx_q + 1'b1;
      end
    end
  end

  ////////////////////
  // array update
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (state_q == INIT_CLEAR) begin
      // tags stay, an invalid way never hits
      valid_q[clear_idx_q]  <= '0;
      dirty_q[clear_idx_q]  <= '0;
      victim_q[clear_idx_q] <= 1'b0;
    end else if (do_lookup) begin
      if (lu_hit) begin
        // a write hit marks the line dirty
        if (lookup_rw_i) begin
          dirty_q[lu_index] <= dirty_q[lu_index] | hit_vec;
        end
      end else begin
        // install the new tag over the victim
        tag_q[lu_index][vic_sel]   <= lu_tag;
        valid_q[lu_index][vic_sel] <= 1'b1;
        dirty_q[lu_index][vic_sel] <= lookup_rw_i;
        victim_q[lu_index]         <= ~vic_sel;
      end
    end
  end

  // result holds until the next lookup
  always_ff @(posedge clk_i) begin
    if (do_lookup) begin
      res_hit_o       <= lu_hit;
      res_way_o       <= lu_hit ? hit_vec : vic_ind;
      res_evict_o     <= ~lu_hit & vic_evict;
      res_evict_tag_o <= tag_q[lu_index][vic_sel];
    end
  end

endmodule

//--- logic/miss_counters.sv
`include "hm_defs.svh"

module miss_counters
  import hm_addr_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic up_valid_i,
  input  id_t  up_id_i,
  input  logic down_valid_i,
  input  id_t  down_id_i,
  input  id_t  query_id_i,
  output logic to_miss_o,
  output logic stall_o
);

  // outstanding misses per id
  cnt_t                   cnt_q [`HM_NUM_IDS];
  logic [`HM_NUM_IDS-1:0] up_sel;
  logic [`HM_NUM_IDS-1:0] down_sel;
  cnt_t                   query_cnt;

  // decode the events onto the counters
  always_comb begin
    for (int i = 0; i < `HM_NUM_IDS; i++) begin
      up_sel[i]   = up_valid_i & (up_id_i == id_t'(i));
      down_sel[i] = down_valid_i & (down_id_i == id_t'(i));
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `HM_NUM_IDS; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `HM_NUM_IDS; i++) begin
        // up and down together leave the count alone
        if (up_sel[i] && !down_sel[i] && (cnt_q[i] != cnt_t'(`HM_CNT_MAX))) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end else if (down_sel[i] && !up_sel[i] && (cnt_q[i] != '0)) begin
          cnt_q[i] <= cnt_q[i] - 1'b1;
        end
      end
    end
  end

  assign query_cnt = cnt_q[query_id_i];
  // misses of this id in flight, keep order through the miss port
  assign to_miss_o = (query_cnt != '0);
  // no room for one more miss of this id
  assign stall_o   = (query_cnt == cnt_t'(`HM_CNT_MAX));

endmodule

//--- logic/line_lock_table.sv
`include "hm_defs.svh"

module line_lock_table
  import hm_addr_pkg::*;
  import hm_ctrl_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     lock_valid_i,
  input  index_t   lock_index_i,
  input  way_ind_t lock_way_i,
  input  logic     unlock_valid_i,
  input  index_t   unlock_index_i,
  input  way_ind_t unlock_way_i,
  input  index_t   query_index_i,
  input  way_ind_t query_way_i,
  output logic     locked_o
);

  // one bit per line, set while the line is in use downstream
  logic [`HM_NUM_SETS-1:0][`HM_NUM_WAYS-1:0] lock_q;
  logic [`HM_NUM_SETS-1:0][`HM_NUM_WAYS-1:0] lock_d;

  ////////////////////
  // next lock state
  ////////////////////

  always_comb begin
    lock_d = lock_q;
    // clear first
    if (unlock_valid_i) begin
      lock_d[unlock_index_i] = lock_d[unlock_index_i] & ~unlock_way_i;
    end
    // so that a lock on the same bit wins
    if (lock_valid_i) begin
      lock_d[lock_index_i] = lock_d[lock_index_i] | lock_way_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q <= '0;
    end else begin
      lock_q <= lock_d;
    end
  end

  // any queried way still locked
  assign locked_o = |(lock_q[query_index_i] & query_way_i);

endmodule

//--- logic/hit_miss_unit.sv
`include "hm_defs.svh"

module hit_miss_unit
  import hm_addr_pkg::*;
  import hm_ctrl_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  // descriptor input
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  addr_t    in_addr_i,
  input  id_t      in_id_i,
  input  logic     in_rw_i,
  // hit and miss ports, shared fields
  output logic     hit_valid_o,
  input  logic     hit_ready_i,
  output logic     miss_valid_o,
  input  logic     miss_ready_i,
  output addr_t    out_addr_o,
  output id_t      out_id_o,
  output logic     out_rw_o,
  output way_ind_t out_way_o,
  output logic     out_evict_o,
  output tag_t     out_evict_tag_o,
  output logic     out_refill_o,
  // line release from downstream
  input  logic     unlock_valid_i,
  input  index_t   unlock_index_i,
  input  way_ind_t unlock_way_i,
  // miss retired downstream
  input  logic     cnt_down_valid_i,
  input  id_t      cnt_down_id_i
);

  unit_state_e state_q;
  unit_state_e state_d;
  // held descriptor
  addr_t       addr_q;
  id_t         id_q;
  logic        rw_q;

  logic        store_ready;
  logic        res_hit;
  way_ind_t    res_way;
  logic        res_evict;
  tag_t        res_evict_tag;
  logic        to_miss;
  logic        cnt_stall;
  logic        locked;
  logic        can_send;
  logic        out_xfer;
  logic        accept;
  index_t      held_index;

  ////////////////////
  // dispatch control
  ////////////////////

  assign held_index = addr_q[`HM_INDEX_LSB +: `HM_INDEX_W];

  // line free and counter has room
  assign can_send     = (state_q == HOLD) & ~locked & ~cnt_stall;
  // hits go to the miss port while misses of the id are out
  assign hit_valid_o  = can_send & res_hit & ~to_miss;
  assign miss_valid_o = can_send & (~res_hit | to_miss);
  assign out_xfer     = (hit_valid_o & hit_ready_i) | (miss_valid_o & miss_ready_i);

  // take a new one when empty, or when the held one leaves now
  assign in_ready_o = in_valid_i & store_ready & ((state_q == IDLE) | out_xfer);
  assign accept     = in_valid_i & in_ready_o;

  always_comb begin
    state_d = state_q;
    if (accept) begin
      state_d = HOLD;
    end else if (out_xfer) begin
      state_d = IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= in_addr_i;
      id_q   <= in_id_i;
      rw_q   <= in_rw_i;
    end
  end

  // output fields, lookup result is held with the descriptor
  assign out_addr_o      = addr_q;
  assign out_id_o        = id_q;
  assign out_rw_o        = rw_q;
  assign out_way_o       = res_way;
  assign out_evict_o     = res_evict;
  assign out_evict_tag_o = res_evict_tag;
  assign out_refill_o    = ~res_hit;

  ////////////////////
  // submodules
  ////////////////////

  // lookup issued in the accept cycle
  tag_store i_tag_store (
    .clk_i           ( clk_i         ),
    .rst_n_i         ( rst_n_i       ),
    .lookup_valid_i  ( accept        ),
    .lookup_addr_i   ( in_addr_i     ),
    .lookup_rw_i     ( in_rw_i       ),
    .store_ready_o   ( store_ready   ),
    .res_hit_o       ( res_hit       ),
    .res_way_o       ( res_way       ),
    .res_evict_o     ( res_evict     ),
    .res_evict_tag_o ( res_evict_tag )
  );

  // count up on every miss port transfer
  miss_counters i_miss_counters (
    .clk_i        ( clk_i                       ),
    .rst_n_i      ( rst_n_i                     ),
    .up_valid_i   ( miss_valid_o & miss_ready_i ),
    .up_id_i      ( id_q                        ),
    .down_valid_i ( cnt_down_valid_i            ),
    .down_id_i    ( cnt_down_id_i               ),
    .query_id_i   ( id_q                        ),
    .to_miss_o    ( to_miss                     ),
    .stall_o      ( cnt_stall                   )
  );

  // line locked by every transfer on either port
  line_lock_table i_line_lock_table (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .lock_valid_i   ( out_xfer       ),
    .lock_index_i   ( held_index     ),
    .lock_way_i     ( res_way        ),
    .unlock_valid_i ( unlock_valid_i ),
    .unlock_index_i ( unlock_index_i ),
    .unlock_way_i   ( unlock_way_i   ),
    .query_index_i  ( held_index     ),
    .query_way_i    ( res_way        ),
    .locked_o       ( locked         )
  );

endmodule

//--- dv/tb_clock_gen.sv
module tb_clock_gen #(
  parameter int period = 10
) (
  output logic clk_o
);

  // free running clock, starts low
  initial begin
    clk_o = 1'b0;
    forever begin
      #(period / 2) clk_o = ~clk_o;
    end
  end

endmodule

//--- dv/hit_miss_tb.sv
module hit_miss_tb
  import hm_addr_pkg::*;
  import hm_ctrl_pkg::*;
();

  logic     clk_i;
  logic     rst_n_i;
  logic     in_valid_i;
  logic     in_ready_o;
  addr_t    in_addr_i;
  id_t      in_id_i;
  logic     in_rw_i;
  logic     hit_valid_o;
  logic     hit_ready_i;
  logic     miss_valid_o;
  logic     miss_ready_i;
  addr_t    out_addr_o;
  id_t      out_id_o;
  logic     out_rw_o;
  way_ind_t out_way_o;
  logic     out_evict_o;
  tag_t     out_evict_tag_o;
  logic     out_refill_o;
  logic     unlock_valid_i;
  index_t   unlock_index_i;
  way_ind_t unlock_way_i;
  logic     cnt_down_valid_i;
  id_t      cnt_down_id_i;

  // pattern commands, loaded before reset release
  logic [7:0]  cmds [256];
  logic [31:0] args [256][8];
  int          num_cmds = 0;
  bit          loaded = 0;

  // expected outputs in input order
  // {port, addr, id, rw, way, evict, evict_tag, refill}
  logic [31:0] exp_q [$];
  int          errors = 0;
  int          checks = 0;
  int          rel_cnt = 0;
  int          stall_window = 0;
  bit          blocked = 0;
  bit          first_done = 0;
  int          hit_stretch = 0;
  int          miss_stretch = 0;
  int          seed_dummy;
  logic [1:0]  held_valid = '0;
  logic [30:0] held_fields = '0;

  tb_clock_gen #(.period(10)) i_clock_gen (.clk_o(clk_i));

  hit_miss_unit i_hit_miss_unit (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .in_valid_i       ( in_valid_i       ),
    .in_ready_o       ( in_ready_o       ),
    .in_addr_i        ( in_addr_i        ),
    .in_id_i          ( in_id_i          ),
    .in_rw_i          ( in_rw_i          ),
    .hit_valid_o      ( hit_valid_o      ),
    .hit_ready_i      ( hit_ready_i      ),
    .miss_valid_o     ( miss_valid_o     ),
    .miss_ready_i     ( miss_ready_i     ),
    .out_addr_o       ( out_addr_o       ),
    .out_id_o         ( out_id_o         ),
    .out_rw_o         ( out_rw_o         ),
    .out_way_o        ( out_way_o        ),
    .out_evict_o      ( out_evict_o      ),
    .out_evict_tag_o  ( out_evict_tag_o  ),
    .out_refill_o     ( out_refill_o     ),
    .unlock_valid_i   ( unlock_valid_i   ),
    .unlock_index_i   ( unlock_index_i   ),
    .unlock_way_i     ( unlock_way_i     ),
    .cnt_down_valid_i ( cnt_down_valid_i ),
    .cnt_down_id_i    ( cnt_down_id_i    )
  );

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("ERROR: %s at %0t", what, $time);
  endtask

  task automatic load_patterns();
    int              fd;
    int              r;
    logic [7:0]      c;
    logic [31:0]     v [8];
    logic [8*128-1:0] skip_line;
    fd = $fopen("dv/hit_miss_patterns.txt", "r");
    if (fd == 0) begin
      report_error("cannot open dv/hit_miss_patterns.txt");
      return;
    end
    while (!$feof(fd)) begin
      r = $fscanf(fd, " %c", c);
      if (r == 1) begin
        for (int k = 0; k < 8; k++) begin
          v[k] = '0;
        end
        case (c)
          "#": r = $fgets(skip_line, fd);
          "A": r = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                           v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
          "U": r = $fscanf(fd, "%h %h", v[0], v[1]);
          "D": r = $fscanf(fd, "%h", v[0]);
          "S": r = $fscanf(fd, "%d", v[0]);
          default: report_error("unknown command in pattern file");
        endcase
        if (c == "A" || c == "U" || c == "D" || c == "S") begin
          cmds[num_cmds] = c;
          for (int k = 0; k < 8; k++) begin
            args[num_cmds][k] = v[k];
          end
          num_cmds++;
        end
      end
    end
    $fclose(fd);
  endtask

  // keep up to keep descriptors outstanding
  task automatic wait_drain(input int keep);
    while (exp_q.size() > keep) begin
      @(posedge clk_i);
    end
  endtask

  task automatic send_access(input int idx);
    logic [31:0] exp;
    exp = {args[idx][3][0], args[idx][0][15:0], args[idx][1][1:0], args[idx][2][0],
           args[idx][4][1:0], args[idx][5][0], args[idx][6][7:0], args[idx][7][0]};
    @(posedge clk_i);
    in_valid_i <= 1'b1;
    in_addr_i  <= args[idx][0][15:0];
    in_id_i    <= args[idx][1][1:0];
    in_rw_i    <= args[idx][2][0];
    // handshake seen mid cycle, taken at the next edge
    @(negedge clk_i);
    while (!in_ready_o) begin
      @(negedge clk_i);
    end
    exp_q.push_back(exp);
    if (!first_done) begin
      // clearing sweep of 16 sets after reset release
      compare_field("in_ready_o rise cycle", rel_cnt, 16);
      first_done = 1;
    end
    @(posedge clk_i);
    in_valid_i <= 1'b0;
    // line still locked, nothing may leave
    if (stall_window != 0) begin
      repeat (stall_window) begin
        @(negedge clk_i);
        compare_field("hit_valid_o", hit_valid_o, 0);
        compare_field("miss_valid_o", miss_valid_o, 0);
      end
      stall_window = 0;
      blocked = 1;
    end
  endtask

  task automatic release_line(input int idx);
    // a blocked descriptor stays behind until this unlock
    wait_drain(blocked ? 1 : 0);
    blocked = 0;
    @(posedge clk_i);
    unlock_valid_i <= 1'b1;
    unlock_index_i <= args[idx][0][3:0];
    unlock_way_i   <= args[idx][1][1:0];
    @(posedge clk_i);
    unlock_valid_i <= 1'b0;
  endtask

  task automatic retire_miss(input int idx);
    wait_drain(0);
    @(posedge clk_i);
    cnt_down_valid_i <= 1'b1;
    cnt_down_id_i    <= args[idx][0][1:0];
    @(posedge clk_i);
    cnt_down_valid_i <= 1'b0;
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      rel_cnt <= 0;
    end else begin
      rel_cnt <= rel_cnt + 1;
    end
  end

  // random low stretches on both readies
  always @(posedge clk_i) begin
    if (hit_stretch != 0) begin
      hit_stretch = hit_stretch - 1;
      hit_ready_i <= 1'b0;
    end else if ($urandom_range(3, 0) == 0) begin
      hit_stretch = $urandom_range(4, 1);
      hit_ready_i <= 1'b0;
    end else begin
      hit_ready_i <= 1'b1;
    end
    if (miss_stretch != 0) begin
      miss_stretch = miss_stretch - 1;
      miss_ready_i <= 1'b0;
    end else if ($urandom_range(3, 0) == 0) begin
      miss_stretch = $urandom_range(4, 1);
      miss_ready_i <= 1'b0;
    end else begin
      miss_ready_i <= 1'b1;
    end
  end

  ////////////////////
  // output monitor
  ////////////////////

  always @(negedge clk_i) begin : out_monitor
    logic [31:0] exp;
    logic [30:0] fields;
    logic [31:0] popped;
    fields = {out_addr_o, out_id_o, out_rw_o, out_way_o, out_evict_o,
              out_evict_tag_o, out_refill_o};
    if (rst_n_i) begin
      // back-pressure keeps valid and fields steady
      if (held_valid != 2'b00) begin
        compare_field("{miss_valid_o, hit_valid_o}", {miss_valid_o, hit_valid_o}, held_valid);
        compare_field("out fields under back-pressure", fields, held_fields);
      end
      held_valid = '0;
      if (hit_valid_o || miss_valid_o) begin
        if (exp_q.size() == 0) begin
          report_error("output valid high with no descriptor outstanding");
        end else begin
          exp = exp_q[0];
          compare_field("hit_valid_o", hit_valid_o, !exp[31]);
          compare_field("miss_valid_o", miss_valid_o, exp[31]);
          compare_field("out_addr_o", out_addr_o, exp[30:15]);
          compare_field("out_id_o", out_id_o, exp[14:13]);
          compare_field("out_rw_o", out_rw_o, exp[12]);
          compare_field("out_way_o", out_way_o, exp[11:10]);
          compare_field("out_evict_o", out_evict_o, exp[9]);
          if (exp[9]) begin
            compare_field("out_evict_tag_o", out_evict_tag_o, exp[8:1]);
          end
          compare_field("out_refill_o", out_refill_o, exp[0]);
          if ((hit_valid_o && hit_ready_i) || (miss_valid_o && miss_ready_i)) begin
            popped = exp_q.pop_front();
          end else begin
            held_valid  = {miss_valid_o, hit_valid_o};
            held_fields = fields;
          end
        end
      end
    end
  end

  ////////////////////
  // main sequence
  ////////////////////

  initial begin : main
    seed_dummy       = $urandom(32'h7dda547e);
    rst_n_i          = 1'b0;
    in_valid_i       = 1'b0;
    in_addr_i        = '0;
    in_id_i          = '0;
    in_rw_i          = 1'b0;
    hit_ready_i      = 1'b0;
    miss_ready_i     = 1'b0;
    unlock_valid_i   = 1'b0;
    unlock_index_i   = '0;
    unlock_way_i     = '0;
    cnt_down_valid_i = 1'b0;
    cnt_down_id_i    = '0;
    load_patterns();
    if (num_cmds == 0) begin
      report_error("no commands loaded from the pattern file");
    end
    loaded = 1;
    // 16 cycles of reset, outputs checked just before release
    repeat (15) @(posedge clk_i);
    @(negedge clk_i);
    compare_field("in_ready_o", in_ready_o, 0);
    compare_field("hit_valid_o", hit_valid_o, 0);
    compare_field("miss_valid_o", miss_valid_o, 0);
    @(posedge clk_i);
    rst_n_i <= 1'b1;
    for (int i = 0; i < num_cmds; i++) begin
      case (cmds[i])
        "A": send_access(i);
        "U": release_line(i);
        "D": retire_miss(i);
        "S": stall_window = args[i][0];
        default: report_error("bad command slot");
      endcase
    end
    wait_drain(0);
    repeat (4) @(posedge clk_i);
    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // bound of 200 cycles per command
  initial begin : watchdog
    wait (loaded);
    repeat ((num_cmds + 1) * 200) @(posedge clk_i);
    $display("timeout: run did not finish within %0d cycles", (num_cmds + 1) * 200);
    $display("errors: %0d, checks: %0d", errors + 1, checks);
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- dv/hit_miss_patterns.txt
# A addr id rw port(0 hit, 1 miss) way evict evict_tag refill, all hex
# U index way (hex), D id (hex), S cycles with no output valid (decimal)
# cold miss, then hit once released
A 0120 0 0 1 1 0 00 1
U 2 1
D 0
A 0124 0 0 0 1 0 00 0
U 2 1
# set 5: both ways filled by writes, third tag evicts way 0
A 0a50 1 1 1 1 0 00 1
U 5 1
D 1
A 0b58 1 1 1 2 0 00 1
U 5 2
D 1
A 0c50 1 0 1 1 1 0a 1
U 5 1
D 1
# hit of an id with a miss outstanding goes to the miss port
A 0370 2 0 1 1 0 00 1
U 7 1
A 0374 2 0 1 1 0 00 0
U 7 1
D 2
D 2
A 0378 2 0 0 1 0 00 0
U 7 1
# access to a locked line waits for the unlock
A 0490 3 1 1 1 0 00 1
D 3
S 20
A 0494 3 0 0 1 0 00 0
U 9 1
U 9 1
# back to back under back-pressure
A 0da0 0 1 1 1 0 00 1
A 0db0 0 0 1 1 0 00 1
A 0128 1 1 0 1 0 00 0
A 0ec0 0 1 1 1 0 00 1
A 0fd0 2 0 1 1 0 00 1
A 0220 3 0 1 2 0 00 1
U a 1
U b 1
U 2 1
U c 1
U d 1
U 2 2
D 0
D 0
D 0
D 2
D 3
# way 0 of set 2 dirty from the write hit
A 0320 3 0 1 1 1 01 1
A 0dac 0 0 0 1 0 00 0
U 2 1
U a 1
D 3

//--- tb.f
+incdir+logic
logic/hm_addr_pkg.sv
logic/hm_ctrl_pkg.sv
logic/tag_store.sv
logic/miss_counters.sv
logic/line_lock_table.sv
logic/hit_miss_unit.sv
dv/tb_clock_gen.sv
dv/hit_miss_tb.sv
